//--- verilog/fx3_bridge_pkg.sv
/* USB 3 slave FIFO bridge constants
 * Bus width, endpoint addresses, buffer sizing, read latency and flush timeout
 */
`default_nettype none

package fx3_bridge_pkg;

   // Peripheral data bus
   localparam int DATA_WIDTH = 16;

   // Endpoint addresses on fx3_a
   localparam logic [1:0] EP_IN  = 2'b00;
   localparam logic [1:0] EP_OUT = 2'b11;

   // Buffers on the user side
   localparam int BUFFER_DEPTH      = 16;
   localparam int ALMOST_FULL_SLACK = 6;

   // Read strobe to data on dq_in
   localparam int READ_LATENCY = 2;

   // Idle cycles before a zero-length packet is forced
   localparam int FLUSH_TIMEOUT = 32;

   // Strobes still issued once the almost flags have fallen
   localparam int DRAIN_READS  = 3;
   localparam int DRAIN_WRITES = 2;

endpackage

`default_nettype wire

//--- verilog/fwft_fifo.sv
/* First-word-fall-through buffer
 * Head word always on rd_data, with full, almost-full and empty flags
 */
`default_nettype none

module fwft_fifo
   import fx3_bridge_pkg::*;
(
   input  logic                  clk_io,
   input  logic                  int_rst,
   input  logic                  wr_en,
   input  logic [DATA_WIDTH-1:0] wr_data,
   input  logic                  rd_en,
   output logic [DATA_WIDTH-1:0] rd_data,
   output logic                  full,
   output logic                  almost_full,
   output logic                  empty
);

   localparam int PTR_W = $clog2(BUFFER_DEPTH);
   localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

   logic [DATA_WIDTH-1:0] mem [BUFFER_DEPTH];
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [CNT_W-1:0]      count;
   logic                  do_wr;
   logic                  do_rd;

   // Requests beyond the flags are ignored
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   assign full        = (count == CNT_W'(BUFFER_DEPTH));
   assign almost_full = (count > CNT_W'(BUFFER_DEPTH - ALMOST_FULL_SLACK));
   assign empty       = (count == '0);
   assign rd_data     = mem[rd_ptr];

   always_ff @(posedge clk_io) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk_io or posedge int_rst) begin
      if (int_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous push and pop keeps the count
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/fx3_read_pipe.sv
/* Read strobe delay line
 * Marks the cycle in which the word of a read strobe sits on dq_in
 */
`default_nettype none

module fx3_read_pipe
   import fx3_bridge_pkg::*;
(
   input  logic clk_io,
   input  logic int_rst,
   input  logic rd,
   output logic data_valid
);

   // One bit per cycle of latency, so back-to-back reads stay in flight
   logic [READ_LATENCY-1:0] stage;

   always_ff @(posedge clk_io or posedge int_rst) begin
      if (int_rst) begin
         stage <= '0;
      end else begin
         stage <= {stage[READ_LATENCY-2:0], rd};
      end
   end

   assign data_valid = stage[READ_LATENCY-1];

endmodule

`default_nettype wire

//--- verilog/fx3_flush_timer.sv
/* Idle flush timer
 * Counts down after a write burst and requests a zero-length packet
 */
`default_nettype none

module fx3_flush_timer
   import fx3_bridge_pkg::*;
(
   input  logic clk_io,
   input  logic int_rst,
   input  logic write_start,
   input  logic write_done,
   input  logic pktend_sent,
   output logic flush_req
);

   localparam int CNT_W = $clog2(FLUSH_TIMEOUT + 1);

   logic [CNT_W-1:0] count;

   always_ff @(posedge clk_io or posedge int_rst) begin
      if (int_rst) begin
         count     <= '0;
         flush_req <= 1'b1;   // one packet end right after start-up
      end else begin
         if (write_start) begin
            count <= '0;
         end else if (write_done) begin
            count <= CNT_W'(FLUSH_TIMEOUT);
         end else if (count != '0) begin
            count <= count - 1'b1;
         end

         // New data cancels any pending request
         if (write_start || pktend_sent) begin
            flush_req <= 1'b0;
         end else if (count == CNT_W'(1)) begin
            flush_req <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/fx3_slave_ctrl.sv
/* Slave FIFO control FSM
 * Chooses between the host-bound and host-originated endpoints and
 * drives the read, write, output-enable and packet-end strobes
 */
`default_nettype none

module fx3_slave_ctrl
   import fx3_bridge_pkg::*;
(
   input  logic       clk_io,
   input  logic       int_rst,
   input  logic       fx3_flaga_n,
   input  logic       fx3_flagb_n,
   input  logic       fx3_flagc_n,
   input  logic       fx3_flagd_n,
   input  logic       egress_empty,
   input  logic       ingress_almost_full,
   input  logic       ingress_full,
   input  logic       flush_req,
   output logic       fx3_slrd_n,
   output logic       fx3_slwr_n,
   output logic       fx3_sloe_n,
   output logic       fx3_pktend_n,
   output logic [1:0] fx3_a,
   output logic       rd,
   output logic       egress_pop,
   output logic       write_start,
   output logic       write_done,
   output logic       pktend_sent
);

   localparam logic [3:0]
      S_IDLE     = 4'd0,
      S_WR_SETUP = 4'd1,
      S_WR_WAIT  = 4'd2,
      S_WRITE    = 4'd3,
      S_WR_DRN1  = 4'd4,
      S_WR_DRN2  = 4'd5,
      S_FLUSH    = 4'd6,
      S_RD_SETUP = 4'd7,
      S_RD_WAIT  = 4'd8,
      S_READ     = 4'd9,
      S_RD_DRN1  = 4'd10,
      S_RD_DRN2  = 4'd11,
      S_RD_DRN3  = 4'd12,
      S_RD_DRN4  = 4'd13,
      S_RD_DRN5  = 4'd14;

   logic [3:0] state;
   logic [3:0] next_state;
   logic       wr;
   logic       oe;
   logic       pktend;

   always_ff @(posedge clk_io or posedge int_rst) begin
      if (int_rst) begin
         state <= S_IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state  = state;
      fx3_a       = EP_IN;
      rd          = 1'b0;
      wr          = 1'b0;
      oe          = 1'b0;
      pktend      = 1'b0;
      write_start = 1'b0;
      write_done  = 1'b0;
      case (state)
         // Write first, then a pending flush, then a read
         S_IDLE: begin
            if (fx3_flaga_n && !egress_empty) begin
               write_start = 1'b1;
               next_state  = S_WR_SETUP;
            end else if (flush_req) begin
               next_state = S_FLUSH;
            end else if (fx3_flagc_n && !ingress_full) begin
               next_state = S_RD_SETUP;
            end
         end
         S_WR_SETUP: next_state = S_WR_WAIT;
         S_WR_WAIT: begin
            if (!fx3_flaga_n) begin
               write_done = 1'b1;
               next_state = S_IDLE;
            end else if (fx3_flagb_n) begin
               next_state = S_WRITE;
            end
         end
         // Running out of egress data ends the burst without drain
         S_WRITE, S_WR_DRN1: begin
            if (egress_empty) begin
               write_done = 1'b1;
               next_state = S_IDLE;
            end else begin
               wr = 1'b1;
               if (state == S_WR_DRN1) begin
                  next_state = S_WR_DRN2;
               end else if (!fx3_flagb_n) begin
                  next_state = S_WR_DRN1;
               end
            end
         end
         S_WR_DRN2: begin
            wr         = !egress_empty;
            write_done = 1'b1;
            next_state = S_IDLE;
         end
         // Zero-length packet only while the endpoint has room
         S_FLUSH: begin
            pktend     = fx3_flaga_n;
            next_state = S_IDLE;
         end
         S_RD_SETUP: begin
            fx3_a      = EP_OUT;
            next_state = S_RD_WAIT;
         end
         S_RD_WAIT: begin
            fx3_a = EP_OUT;
            if (!fx3_flagc_n) begin
               next_state = S_IDLE;
            end else if (fx3_flagd_n) begin
               next_state = S_READ;
            end else if (!ingress_almost_full) begin
               next_state = S_RD_DRN1;   // last few words
            end else begin
               next_state = S_IDLE;
            end
         end
         S_READ: begin
            fx3_a = EP_OUT;
            rd    = 1'b1;
            oe    = 1'b1;
            if (!fx3_flagd_n) begin
               next_state = S_RD_DRN1;
            end else if (ingress_almost_full) begin
               next_state = S_RD_DRN4;
            end
         end
         S_RD_DRN1, S_RD_DRN2, S_RD_DRN3: begin
            fx3_a      = EP_OUT;
            rd         = 1'b1;
            oe         = 1'b1;
            next_state = state + 4'd1;
         end
         // Output enable held while the last reads return
         S_RD_DRN4, S_RD_DRN5: begin
            fx3_a      = EP_OUT;
            oe         = 1'b1;
            next_state = (state == S_RD_DRN5) ? S_IDLE : S_RD_DRN5;
         end
         default: next_state = S_IDLE;
      endcase
   end

   assign fx3_slrd_n   = ~rd;
   assign fx3_slwr_n   = ~wr;
   assign fx3_sloe_n   = ~oe;
   assign fx3_pktend_n = ~pktend;
   assign egress_pop   = wr;
   assign pktend_sent  = pktend;

endmodule

`default_nettype wire

//--- verilog/fx3_bridge_top.sv
/* USB 3 slave FIFO bridge
 * Connects user valid/ready streams to the peripheral slave FIFO port
 * through one buffer per direction
 */
`default_nettype none

module fx3_bridge_top
   import fx3_bridge_pkg::*;
(
   input  logic                  clk_io,
   input  logic                  int_rst,
   // User egress, toward the host
   input  logic                  out_valid,
   input  logic [DATA_WIDTH-1:0] out_data,
   output logic                  out_ready,
   // User ingress, from the host
   output logic                  in_valid,
   output logic [DATA_WIDTH-1:0] in_data,
   input  logic                  in_ready,
   // Peripheral slave FIFO port
   input  logic [DATA_WIDTH-1:0] dq_in,
   output logic [DATA_WIDTH-1:0] dq_out,
   output logic                  dq_oe,
   input  logic                  fx3_flaga_n,
   input  logic                  fx3_flagb_n,
   input  logic                  fx3_flagc_n,
   input  logic                  fx3_flagd_n,
   output logic                  fx3_slrd_n,
   output logic                  fx3_slwr_n,
   output logic                  fx3_sloe_n,
   output logic                  fx3_pktend_n,
   output logic [1:0]            fx3_a
);

   logic egress_empty;
   logic egress_full;
   logic egress_pop;
   logic ingress_empty;
   logic ingress_full;
   logic ingress_almost_full;
   logic ingress_wr;
   logic rd;
   logic data_valid;
   logic write_start;
   logic write_done;
   logic pktend_sent;
   logic flush_req;

   // Bus driven only while addressing the host-bound endpoint
   assign dq_oe = (fx3_a == EP_IN);

   assign out_ready = ~egress_full;
   assign in_valid  = ~ingress_empty;

   // flagc_n arrives with its word and qualifies it
   assign ingress_wr = data_valid && fx3_flagc_n;

   fx3_slave_ctrl u_ctrl (
      .clk_io              (clk_io),
      .int_rst             (int_rst),
      .fx3_flaga_n         (fx3_flaga_n),
      .fx3_flagb_n         (fx3_flagb_n),
      .fx3_flagc_n         (fx3_flagc_n),
      .fx3_flagd_n         (fx3_flagd_n),
      .egress_empty        (egress_empty),
      .ingress_almost_full (ingress_almost_full),
      .ingress_full        (ingress_full),
      .flush_req           (flush_req),
      .fx3_slrd_n          (fx3_slrd_n),
      .fx3_slwr_n          (fx3_slwr_n),
      .fx3_sloe_n          (fx3_sloe_n),
      .fx3_pktend_n        (fx3_pktend_n),
      .fx3_a               (fx3_a),
      .rd                  (rd),
      .egress_pop          (egress_pop),
      .write_start         (write_start),
      .write_done          (write_done),
      .pktend_sent         (pktend_sent)
   );

   fx3_read_pipe u_read_pipe (
      .clk_io     (clk_io),
      .int_rst    (int_rst),
      .rd         (rd),
      .data_valid (data_valid)
   );

   fx3_flush_timer u_flush_timer (
      .clk_io      (clk_io),
      .int_rst     (int_rst),
      .write_start (write_start),
      .write_done  (write_done),
      .pktend_sent (pktend_sent),
      .flush_req   (flush_req)
   );

   fwft_fifo u_egress_buf (
      .clk_io      (clk_io),
      .int_rst     (int_rst),
      .wr_en       (out_valid),
      .wr_data     (out_data),
      .rd_en       (egress_pop),
      .rd_data     (dq_out),
      .full        (egress_full),
      .almost_full (),
      .empty       (egress_empty)
   );

   fwft_fifo u_ingress_buf (
      .clk_io      (clk_io),
      .int_rst     (int_rst),
      .wr_en       (ingress_wr),
      .wr_data     (dq_in),
      .rd_en       (in_ready),
      .rd_data     (in_data),
      .full        (ingress_full),
      .almost_full (ingress_almost_full),
      .empty       (ingress_empty)
   );

endmodule

`default_nettype wire

//--- bench/fx3_bridge_chk.sv
/* Bridge protocol checker
 * Concurrent assertions on the peripheral strobes, address and reset state
 */
`default_nettype none

module fx3_bridge_chk
   import fx3_bridge_pkg::*;
(
   input  logic       clk_io,
   input  logic       int_rst,
   input  logic       fx3_slrd_n,
   input  logic       fx3_slwr_n,
   input  logic       fx3_sloe_n,
   input  logic       fx3_pktend_n,
   input  logic [1:0] fx3_a,
   input  logic       dq_oe,
   input  logic       fx3_flaga_n,
   input  logic       fx3_flagb_n,
   input  logic       fx3_flagd_n,
   input  logic       in_valid,
   input  logic       out_ready,
   input  logic       egress_empty
);
   timeunit 1ns;
   timeprecision 100ps;

   // Read by the testbench to end the run
   int fail_count = 0;

   a_reset_state: assert property (@(posedge clk_io) $fell(int_rst) |->
      fx3_slrd_n && fx3_slwr_n && fx3_sloe_n && fx3_pktend_n && !in_valid && out_ready)
      else begin fail_count++; $error("strobes or user flags wrong after reset"); end

   a_strobe_excl: assert property (@(posedge clk_io) disable iff (int_rst)
      !(!fx3_slrd_n && !fx3_slwr_n) && !(!fx3_pktend_n && !(fx3_slrd_n && fx3_slwr_n)))
      else begin fail_count++; $error("strobes active together"); end

   a_write_room: assert property (@(posedge clk_io) disable iff (int_rst)
      !fx3_slwr_n |-> fx3_flaga_n && fx3_a == EP_IN && dq_oe)
      else begin fail_count++; $error("write into full endpoint or wrong address"); end

   a_read_addr: assert property (@(posedge clk_io) disable iff (int_rst)
      (!fx3_slrd_n || !fx3_sloe_n) |-> fx3_a == EP_OUT && !dq_oe)
      else begin fail_count++; $error("read with wrong address or bus driven"); end

   a_pktend_room: assert property (@(posedge clk_io) disable iff (int_rst)
      !fx3_pktend_n |-> fx3_flaga_n)
      else begin fail_count++; $error("packet end into full endpoint"); end

   // Two more writes after almost-full, fewer only if the egress buffer ran dry
   a_write_drain: assert property (@(posedge clk_io) disable iff (int_rst)
      (!fx3_slwr_n && !fx3_flagb_n && $past(fx3_flagb_n)) |=>
      (!fx3_slwr_n || egress_empty) ##1 (!fx3_slwr_n || egress_empty) ##1 fx3_slwr_n)
      else begin fail_count++; $error("write drain length wrong"); end

   // Three drain reads, then two cycles of output enable only
   a_read_drain: assert property (@(posedge clk_io) disable iff (int_rst)
      (!fx3_slrd_n && !fx3_flagd_n && $past(fx3_flagd_n)) |=>
      (!fx3_slrd_n)[*3] ##1 (fx3_slrd_n && !fx3_sloe_n)[*2] ##1 fx3_sloe_n)
      else begin fail_count++; $error("read drain length wrong"); end

endmodule

bind fx3_bridge_top fx3_bridge_chk u_chk (
   .clk_io       (clk_io),
   .int_rst      (int_rst),
   .fx3_slrd_n   (fx3_slrd_n),
   .fx3_slwr_n   (fx3_slwr_n),
   .fx3_sloe_n   (fx3_sloe_n),
   .fx3_pktend_n (fx3_pktend_n),
   .fx3_a        (fx3_a),
   .dq_oe        (dq_oe),
   .fx3_flaga_n  (fx3_flaga_n),
   .fx3_flagb_n  (fx3_flagb_n),
   .fx3_flagd_n  (fx3_flagd_n),
   .in_valid     (in_valid),
   .out_ready    (out_ready),
   .egress_empty (egress_empty)
);

`default_nettype wire

//--- bench/fx3_bridge_tb.sv
/* Bridge testbench
 * Models both peripheral endpoints, drives the user streams and
 * checks data order and the flush timing
 */
`default_nettype none

module fx3_bridge_tb
   import fx3_bridge_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int HOST_WORDS = 40;
   localparam int USER_WORDS = 64;
   localparam int SINK_DEPTH = 24;
   localparam int MAX_CYCLES = 2000;

   logic clk_io = 1'b0;
   logic int_rst;
   logic out_valid, out_ready, in_valid, in_ready, dq_oe;
   logic [DATA_WIDTH-1:0] out_data, in_data, dq_in, dq_out;
   logic fx3_flaga_n, fx3_flagb_n, fx3_flagc_n, fx3_flagd_n;
   logic fx3_slrd_n, fx3_slwr_n, fx3_sloe_n, fx3_pktend_n;
   logic [1:0] fx3_a;

   logic [DATA_WIDTH-1:0] host_q[$];
   logic [DATA_WIDTH-1:0] host_exp[$];
   logic [DATA_WIDTH-1:0] user_words[$];
   logic [DATA_WIDTH-1:0] ret_data[READ_LATENCY];
   logic                  ret_valid[READ_LATENCY];
   int pkt_cycles[$];
   int cycle = 0, sink_fill = 0, wr_count = 0, in_count = 0, eg_idx = 0, last_wr = 0;
   logic eg_run = 1'b0;
   logic s_wr = 1'b0;
   logic s_rd = 1'b0;
   logic s_pkt = 1'b0;
   logic s_eg = 1'b0;
   logic s_in = 1'b0;
   logic [DATA_WIDTH-1:0] s_dq = '0;
   logic [DATA_WIDTH-1:0] s_in_data = '0;

   fx3_bridge_top u_dut (.*);

   always #5 clk_io = ~clk_io;

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] exp);
      if (got !== exp) begin
         $display("Error: %s = %h, expected %h", name, got, exp);
         fail_run("data mismatch");
      end
   endtask

   // Outputs are stable mid-cycle
   always @(negedge clk_io) begin
      s_wr      = !fx3_slwr_n;
      s_rd      = !fx3_slrd_n;
      s_pkt     = !fx3_pktend_n;
      s_dq      = dq_out;
      s_eg      = out_valid && out_ready;
      s_in      = in_valid && in_ready;
      s_in_data = in_data;
   end

   always @(posedge clk_io) begin
      #1;
      cycle++;
      if (u_dut.u_chk.fail_count != 0) fail_run("a protocol assertion failed");
      if (cycle >= MAX_CYCLES) fail_run("timeout, the run did not finish in time");
      // Host-bound sink, drained by the host only between strobes
      if (s_wr) begin
         if (sink_fill >= SINK_DEPTH) fail_run("write strobe into a full endpoint");
         if (wr_count >= USER_WORDS) fail_run("more words reached the host than were sent");
         check_word("dq_out", s_dq, user_words[wr_count]);
         wr_count++;
         sink_fill++;
         last_wr = cycle;
      end else if (sink_fill > 0 && $urandom_range(3, 0) == 0) begin
         sink_fill--;
      end
      if (s_pkt) pkt_cycles.push_back(cycle);
      // Host-originated source with its return pipeline
      for (int i = READ_LATENCY - 1; i > 0; i--) begin
         ret_valid[i] = ret_valid[i-1];
         ret_data[i]  = ret_data[i-1];
      end
      ret_valid[0] = s_rd && host_q.size() > 0;
      ret_data[0]  = ret_valid[0] ? host_q.pop_front() : '0;
      dq_in       = ret_data[READ_LATENCY-1];
      fx3_flagc_n = (host_q.size() > 0) || ret_valid[READ_LATENCY-1];
      fx3_flagd_n = host_q.size() > 3;
      // Three free entries cover the write already in flight
      fx3_flaga_n = sink_fill < SINK_DEPTH;
      fx3_flagb_n = sink_fill < SINK_DEPTH - 3;
      if (s_in) begin
         if (in_count >= HOST_WORDS) fail_run("extra word delivered on in_data");
         check_word("in_data", s_in_data, host_exp[in_count]);
         in_count++;
      end
      in_ready = $urandom_range(3, 0) != 0;
      if (s_eg) eg_idx++;
      out_valid = eg_run && eg_idx < USER_WORDS;
      out_data  = (eg_idx < USER_WORDS) ? user_words[eg_idx] : '0;
   end

   initial begin
      int n_after;
      int n_outside;
      void'($urandom(6834));
      for (int i = 0; i < HOST_WORDS; i++) host_q.push_back(DATA_WIDTH'($urandom));
      host_exp = host_q;
      for (int i = 0; i < USER_WORDS; i++) user_words.push_back(DATA_WIDTH'($urandom));
      for (int i = 0; i < READ_LATENCY; i++) begin
         ret_valid[i] = 1'b0;
         ret_data[i]  = '0;
      end
      int_rst     = 1'b1;
      out_valid   = 1'b0;
      out_data    = '0;
      in_ready    = 1'b0;
      dq_in       = '0;
      fx3_flaga_n = 1'b1;
      fx3_flagb_n = 1'b1;
      fx3_flagc_n = 1'b1;
      fx3_flagd_n = 1'b1;
      repeat (3) @(posedge clk_io);
      #1 int_rst = 1'b0;
      // Start-up packet end, then the host words, then the user words
      while (pkt_cycles.size() == 0) @(posedge clk_io);
      while (in_count < HOST_WORDS) @(posedge clk_io);
      eg_run = 1'b1;
      while (wr_count < USER_WORDS) @(posedge clk_io);
      while (cycle < last_wr + FLUSH_TIMEOUT + 8) @(posedge clk_io);
      #2;
      n_after   = 0;
      n_outside = 0;
      foreach (pkt_cycles[i]) begin
         if (pkt_cycles[i] > last_wr) begin
            n_after++;
            if (pkt_cycles[i] - last_wr < FLUSH_TIMEOUT ||
                pkt_cycles[i] - last_wr > FLUSH_TIMEOUT + 3) begin
               n_outside++;
            end
         end
      end
      if (n_outside != 0) begin
         fail_run("idle packet end came outside its window");
      end else if (n_after != 1) begin
         fail_run("not exactly one packet end after the last write");
      end else begin
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- fx3_bridge_top.f
verilog/fx3_bridge_pkg.sv
verilog/fwft_fifo.sv
verilog/fx3_read_pipe.sv
verilog/fx3_flush_timer.sv
verilog/fx3_slave_ctrl.sv
verilog/fx3_bridge_top.sv
bench/fx3_bridge_chk.sv
bench/fx3_bridge_tb.sv

//--- Makefile
# Verilator build and run of the USB 3 slave FIFO bridge testbench

VERILATOR ?= verilator
TOP       ?= fx3_bridge_tb
FILELIST  ?= fx3_bridge_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)
